// File: video_pkg.sv
// ***************************************************************************
// Pixel and sync types of the video output path. Game colour arrives at
// 4 bits per channel and leaves at 6 bits for the board DAC. Modules take
// these by importing the package in their header.
// ***************************************************************************
`default_nettype none

package video_pkg;

    localparam int GAME_CW = 4;         // Game colour channel width
    localparam int DAC_CW  = 6;         // Board DAC channel width
    localparam int POS_W   = 9;         // Active area column or line index

    typedef logic [GAME_CW-1:0] color4_t;
    typedef logic [DAC_CW-1:0]  color6_t;
    typedef logic [POS_W-1:0]   pos_t;

    // Pixel as delivered by the core, qualified by pxl_cen
    typedef struct packed {
        color4_t r;
        color4_t g;
        color4_t b;
        logic    hs;        // Active high
        logic    vs;        // Active high
        logic    lhbl;      // High on visible pixels of a line
        logic    lvbl;      // High on visible lines
    } game_px_t;

    // Pixel after the OSD mix, already at DAC width
    typedef struct packed {
        color6_t r;
        color6_t g;
        color6_t b;
        logic    hs;
        logic    vs;
    } out_px_t;

endpackage

`default_nettype wire

// File: osd_pkg.sv
// ***************************************************************************
// OSD window geometry, loader command codes and the buffer write bundle.
// Byte n of the bitmap covers window line n/8, columns 8*(n%8) upwards,
// with bit 0 as the leftmost pixel.
// ***************************************************************************
`default_nettype none

package osd_pkg;

    localparam int OSD_X0    = 16;      // Window origin in active pixels
    localparam int OSD_Y0    = 8;
    localparam int OSD_W     = 64;      // Window size in pixels
    localparam int OSD_H     = 16;
    localparam int OSD_BYTES = 128;     // One bit per window pixel

    localparam logic [7:0] CMD_SET_ADDR = 8'h20;
    localparam logic [7:0] CMD_OSD_OFF  = 8'h40;
    localparam logic [7:0] CMD_OSD_ON   = 8'h41;

    typedef logic [6:0] osd_addr_t;

    typedef struct packed {
        logic      we;
        osd_addr_t addr;
        logic [7:0] data;
    } osd_wr_t;

    typedef enum logic [1:0] {OSD_IDLE, OSD_ADDR, OSD_DATA} osd_state_t;

endpackage

`default_nettype wire

// File: osd_loader.sv
// ***************************************************************************
// Byte port decoder for the OSD. Command strobes select the address or
// switch the OSD on and off, data strobes carry the address and then the
// bitmap bytes. Each accepted data byte becomes one registered buffer write.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module osd_loader import osd_pkg::*; (
    input  wire logic       clk_sys,
    input  wire logic       rst_n,
    input  wire logic       osd_cmd_wr,
    input  wire logic       osd_data_wr,
    input  wire logic [7:0] osd_byte,
    output osd_wr_t         osd_wr,
    output logic            osd_enable
);

    osd_state_t state;
    osd_addr_t  wr_addr;        // Next buffer address, auto increments
    osd_addr_t  out_addr;
    logic [7:0] out_data;
    logic       out_we;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state      <= OSD_IDLE;
            wr_addr    <= '0;
            out_we     <= 1'b0;
            osd_enable <= 1'b0;
        end else begin
            out_we <= 1'b0;
            if (osd_cmd_wr) begin
                case (osd_byte)
                    CMD_SET_ADDR: state <= OSD_ADDR;
                    CMD_OSD_ON: begin
                        osd_enable <= 1'b1;
                        state      <= OSD_IDLE;
                    end
                    CMD_OSD_OFF: begin
                        osd_enable <= 1'b0;
                        state      <= OSD_IDLE;
                    end
                    default: state <= OSD_IDLE;     // Unknown codes just stop a load
                endcase
            end else if (osd_data_wr) begin
                case (state)
                    OSD_ADDR: begin
                        wr_addr <= osd_byte[6:0];
                        state   <= OSD_DATA;
                    end
                    OSD_DATA: begin
                        out_we  <= 1'b1;
                        wr_addr <= wr_addr + 1'b1;  // Wraps at 128
                    end
                    default: ;                      // Stray data in idle
                endcase
            end
        end
    end

    // Write payload, only looked at while out_we is high
    always_ff @(posedge clk_sys) begin
        if (osd_data_wr) begin
            out_addr <= wr_addr;
            out_data <= osd_byte;
        end
    end

    assign osd_wr = '{we: out_we, addr: out_addr, data: out_data};

endmodule

`default_nettype wire

// File: video_pos_counter.sv
// ***************************************************************************
// Column and line of the current input pixel inside the active area,
// derived from the blanking strobes. Both indices read 0 while blanked.
// Counters only advance on pixel clock enable cycles.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module video_pos_counter import video_pkg::*; (
    input  wire logic clk_sys,
    input  wire logic rst_n,
    input  wire logic pxl_cen,
    input  wire logic lhbl,
    input  wire logic lvbl,
    output pos_t      h_pos,
    output pos_t      v_pos
);

    pos_t h_cnt;            // Visible pixels seen so far on this line
    pos_t v_cnt;            // Visible lines completed in this frame
    logic lhbl_last;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            lhbl_last <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_last <= lhbl;
            if (lhbl) begin
                h_cnt <= h_cnt + 1'b1;
            end else begin
                h_cnt <= '0;
            end
            if (!lvbl) begin
                v_cnt <= '0;
            end else if (lhbl_last && !lhbl) begin
                v_cnt <= v_cnt + 1'b1;      // First blank pixel ends the line
            end
        end
    end

    // Counter already holds the index of the pixel now at the input
    assign h_pos = lhbl ? h_cnt : '0;
    assign v_pos = lvbl ? v_cnt : '0;

endmodule

`default_nettype wire

// File: osd_overlay.sv
// ***************************************************************************
// OSD bitmap store and mixer. Inside the enabled window a set bit paints
// the pixel white and a clear bit halves the game colour. The mixed pixel
// is expanded to DAC width and registered with its syncs on pxl_cen.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module osd_overlay import video_pkg::*, osd_pkg::*; (
    input  wire logic clk_sys,
    input  wire logic rst_n,
    input  wire logic pxl_cen,
    input  game_px_t  game_px,
    input  pos_t      h_pos,
    input  pos_t      v_pos,
    input  osd_wr_t   osd_wr,
    input  wire logic osd_enable,
    output out_px_t   mix_px
);

    logic [7:0] osd_mem [OSD_BYTES];
    pos_t       rel_x;
    pos_t       rel_y;
    osd_addr_t  rd_addr;
    logic       in_win;
    logic       osd_bit;
    color4_t    mix_r, mix_g, mix_b;

    // 4 to 6 bits by repeating the top bits
    function automatic color6_t expand(input color4_t c);
        return {c, c[3:2]};
    endfunction

    always_ff @(posedge clk_sys) begin
        if (osd_wr.we) osd_mem[osd_wr.addr] <= osd_wr.data;
    end

    // Left of or above the window wraps to a large value
    assign rel_x   = h_pos - pos_t'(OSD_X0);
    assign rel_y   = v_pos - pos_t'(OSD_Y0);
    assign in_win  = osd_enable && game_px.lhbl && game_px.lvbl &&
                     (rel_x < pos_t'(OSD_W)) && (rel_y < pos_t'(OSD_H));
    assign rd_addr = {rel_y[3:0], rel_x[5:3]};    // 8 bytes per window line
    assign osd_bit = osd_mem[rd_addr][rel_x[2:0]];

    always_comb begin
        mix_r = game_px.r;
        mix_g = game_px.g;
        mix_b = game_px.b;
        if (in_win) begin
            if (osd_bit) begin
                mix_r = 4'hF;
                mix_g = 4'hF;
                mix_b = 4'hF;
            end else begin
                mix_r = game_px.r >> 1;     // Dimmed background
                mix_g = game_px.g >> 1;
                mix_b = game_px.b >> 1;
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            mix_px <= '0;
        end else if (pxl_cen) begin
            mix_px <= '{r: expand(mix_r), g: expand(mix_g), b: expand(mix_b),
                        hs: game_px.hs, vs: game_px.vs};
        end
    end

endmodule

`default_nettype wire

// File: rgb2ypbpr.sv
// ***************************************************************************
// Combinational RGB to YPbPr conversion at 6 bits per channel.
// Weights are in 1/256 units and the chroma outputs are centred on 32.
// Every result is clamped to the DAC range.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module rgb2ypbpr import video_pkg::*; (
    input  color6_t r,
    input  color6_t g,
    input  color6_t b,
    output color6_t y,
    output color6_t pb,
    output color6_t pr
);

    logic signed [15:0] rs, gs, bs;
    logic signed [15:0] y_val, pb_val, pr_val;

    function automatic color6_t clamp6(input logic signed [15:0] v);
        if (v < 16'sd0) return '0;
        if (v > 16'sd63) return 6'd63;
        return v[5:0];
    endfunction

    // Zero extend into a signed range wide enough for all sums
    assign rs = signed'({10'd0, r});
    assign gs = signed'({10'd0, g});
    assign bs = signed'({10'd0, b});

    assign y_val  = (16'sd77 * rs + 16'sd150 * gs + 16'sd29 * bs) >>> 8;
    assign pb_val = 16'sd32 + ((16'sd128 * bs - 16'sd43 * rs - 16'sd85 * gs) >>> 8);
    assign pr_val = 16'sd32 + ((16'sd128 * rs - 16'sd107 * gs - 16'sd21 * bs) >>> 8);

    assign y  = clamp6(y_val);
    assign pb = clamp6(pb_val);
    assign pr = clamp6(pr_val);

endmodule

`default_nettype wire

// File: video_out_mux.sv
// ***************************************************************************
// Output registers for the board video connector. In RGB mode the mixed
// colour and syncs go straight out. In YPbPr mode the channels carry
// Pr, Y and Pb, HS carries composite sync and VS is held high.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module video_out_mux import video_pkg::*; (
    input  wire logic clk_sys,
    input  wire logic rst_n,
    input  wire logic ypbpr,
    input  out_px_t   mix_px,
    input  color6_t   y,
    input  color6_t   pb,
    input  color6_t   pr,
    output color6_t   vga_r,
    output color6_t   vga_g,
    output color6_t   vga_b,
    output logic      vga_hs,
    output logic      vga_vs
);

    logic csync;

    // Low during either sync pulse, high again when both overlap
    assign csync = ~(mix_px.hs ^ mix_px.vs);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
            vga_hs <= 1'b0;
            vga_vs <= 1'b0;
        end else if (ypbpr) begin
            vga_r  <= pr;
            vga_g  <= y;
            vga_b  <= pb;
            vga_hs <= csync;
            vga_vs <= 1'b1;     // Tells the cable to switch mode
        end else begin
            vga_r  <= mix_px.r;
            vga_g  <= mix_px.g;
            vga_b  <= mix_px.b;
            vga_hs <= mix_px.hs;
            vga_vs <= mix_px.vs;
        end
    end

endmodule

`default_nettype wire

// File: video_base.sv
// ***************************************************************************
// Video output stage of the board wrapper. Game pixels pass through the
// OSD mixer and leave as 6-bit RGB or YPbPr two clocks later. The OSD is
// loaded through a byte port with separate command and data strobes.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module video_base import video_pkg::*, osd_pkg::*; (
    input  wire logic       clk_sys,
    input  wire logic       rst_n,
    input  wire logic       pxl_cen,
    input  wire logic       ypbpr,
    input  game_px_t        game_px,
    input  wire logic       osd_cmd_wr,
    input  wire logic       osd_data_wr,
    input  wire logic [7:0] osd_byte,
    output color6_t         vga_r,
    output color6_t         vga_g,
    output color6_t         vga_b,
    output logic            vga_hs,
    output logic            vga_vs
);

    osd_wr_t osd_wr;
    logic    osd_enable;
    pos_t    h_pos, v_pos;
    out_px_t mix_px;
    color6_t y, pb, pr;

    osd_loader u_loader (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .osd_cmd_wr  ( osd_cmd_wr  ),
        .osd_data_wr ( osd_data_wr ),
        .osd_byte    ( osd_byte    ),
        .osd_wr      ( osd_wr      ),
        .osd_enable  ( osd_enable  )
    );

    video_pos_counter u_pos (
        .clk_sys ( clk_sys      ),
        .rst_n   ( rst_n        ),
        .pxl_cen ( pxl_cen      ),
        .lhbl    ( game_px.lhbl ),
        .lvbl    ( game_px.lvbl ),
        .h_pos   ( h_pos        ),
        .v_pos   ( v_pos        )
    );

    osd_overlay u_overlay (
        .clk_sys    ( clk_sys    ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .game_px    ( game_px    ),
        .h_pos      ( h_pos      ),
        .v_pos      ( v_pos      ),
        .osd_wr     ( osd_wr     ),
        .osd_enable ( osd_enable ),
        .mix_px     ( mix_px     )
    );

    rgb2ypbpr u_rgb2ypbpr (
        .r  ( mix_px.r ),
        .g  ( mix_px.g ),
        .b  ( mix_px.b ),
        .y  ( y        ),
        .pb ( pb       ),
        .pr ( pr       )
    );

    video_out_mux u_out (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .ypbpr   ( ypbpr   ),
        .mix_px  ( mix_px  ),
        .y       ( y       ),
        .pb      ( pb      ),
        .pr      ( pr      ),
        .vga_r   ( vga_r   ),
        .vga_g   ( vga_g   ),
        .vga_b   ( vga_b   ),
        .vga_hs  ( vga_hs  ),
        .vga_vs  ( vga_vs  )
    );

endmodule

`default_nettype wire

// File: video_base_assert.sv
// ***************************************************************************
// Concurrent checks on the video output stage, attached to every
// video_base instance by the bind at the bottom of this file.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module video_base_assert import video_pkg::*; (
    input wire logic    clk_sys,
    input wire logic    rst_n,
    input wire logic    ypbpr,
    input wire logic    osd_we,
    input wire color6_t vga_r,
    input wire color6_t vga_g,
    input wire color6_t vga_b,
    input wire logic    vga_hs,
    input wire logic    vga_vs
);

    // Output register has followed the mode by then
    vs_high_in_ypbpr: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ypbpr && $past(ypbpr) |-> vga_vs)
        else $error("vga_vs low although YPbPr mode is selected");

    single_cycle_write: assert property (@(posedge clk_sys) disable iff (!rst_n)
        osd_we |=> !osd_we)
        else $error("OSD buffer write strobe high on two cycles in a row");

    outputs_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !$isunknown({vga_r, vga_g, vga_b, vga_hs, vga_vs}))
        else $error("Video outputs carry unknown bits");

endmodule

bind video_base video_base_assert u_video_assert (
    .clk_sys ( clk_sys   ),
    .rst_n   ( rst_n     ),
    .ypbpr   ( ypbpr     ),
    .osd_we  ( osd_wr.we ),
    .vga_r   ( vga_r     ),
    .vga_g   ( vga_g     ),
    .vga_b   ( vga_b     ),
    .vga_hs  ( vga_hs    ),
    .vga_vs  ( vga_vs    )
);

`default_nettype wire

// File: tb_video_base.sv
// ***************************************************************************
// Testbench for the video output stage. Replays the records of
// video_stimulus.txt, drives frames and OSD loads, predicts every output
// pixel from a model of the OSD and colour rules and checks it.
// ***************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_video_base import video_pkg::*, osd_pkg::*; ();

    localparam int LINE_PX  = 104;      // 96 visible plus 8 blank
    localparam int FRAME_LN = 34;       // 32 visible plus 2 blank

    typedef struct packed {
        logic [31:0] due;               // Negedge count when the output shows it
        logic [8:0]  col;
        logic [8:0]  line;
        logic        vis;
        out_px_t     px;
    } exp_px_t;

    logic        clk_sys = 1'b0;
    logic        rst_n;
    logic        pxl_cen;
    logic        ypbpr;
    game_px_t    game_px;
    logic        osd_cmd_wr;
    logic        osd_data_wr;
    logic [7:0]  osd_byte;
    color6_t     vga_r, vga_g, vga_b;
    logic        vga_hs, vga_vs;

    exp_px_t     exp_q [$];
    out_px_t     cap [32][96];          // Visible outputs of the last frame
    logic [7:0]  bm_model [OSD_BYTES];
    logic        osd_on_model;
    osd_state_t  ld_state;
    osd_addr_t   ld_addr;
    logic [31:0] rnd_state = 32'd71910;
    int          neg_cnt = 0;
    int          mismatch_cnt = 0;
    int          other_err_cnt = 0;
    string       test_name = "reset";

    video_base dut_i (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pxl_cen     ( pxl_cen     ),
        .ypbpr       ( ypbpr       ),
        .game_px     ( game_px     ),
        .osd_cmd_wr  ( osd_cmd_wr  ),
        .osd_data_wr ( osd_data_wr ),
        .osd_byte    ( osd_byte    ),
        .vga_r       ( vga_r       ),
        .vga_g       ( vga_g       ),
        .vga_b       ( vga_b       ),
        .vga_hs      ( vga_hs      ),
        .vga_vs      ( vga_vs      )
    );

    always #2 clk_sys = ~clk_sys;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [3:0] hex_nibble(input logic [7:0] ch);
        if (ch >= "A") return 4'(ch - "A" + 8'd10);
        return 4'(ch - "0");
    endfunction

    function automatic int clamp6(input int v);
        if (v < 0) return 0;
        if (v > 63) return 63;
        return v;
    endfunction

    // Expected output for one input pixel
    function automatic out_px_t ref_pixel(input logic [11:0] rgb, input int col,
                                          input int line, input logic hs,
                                          input logic vs, input logic mode);
        logic [3:0] c [3];
        int         wx, wy, ri, gi, bi;
        out_px_t    p;
        c[0] = rgb[11:8];
        c[1] = rgb[7:4];
        c[2] = rgb[3:0];
        wx = col - OSD_X0;
        wy = line - OSD_Y0;
        if (osd_on_model && col < 96 && line < 32 && wx >= 0 && wx < OSD_W &&
            wy >= 0 && wy < OSD_H) begin
            for (int i = 0; i < 3; i++) begin
                c[i] = bm_model[wy * 8 + wx / 8][wx % 8] ? 4'hF : c[i] >> 1;
            end
        end
        ri = {c[0], c[0][3:2]};     // Top bits repeated below
        gi = {c[1], c[1][3:2]};
        bi = {c[2], c[2][3:2]};
        if (mode) begin
            p.r  = 6'(clamp6(32 + ((128 * ri - 107 * gi - 21 * bi) >>> 8)));
            p.g  = 6'(clamp6((77 * ri + 150 * gi + 29 * bi) >>> 8));
            p.b  = 6'(clamp6(32 + ((128 * bi - 43 * ri - 85 * gi) >>> 8)));
            p.hs = ~(hs ^ vs);
            p.vs = 1'b1;
        end else begin
            p = '{r: 6'(ri), g: 6'(gi), b: 6'(bi), hs: hs, vs: vs};
        end
        return p;
    endfunction

    // One strobe, one idle cycle, then the loader model follows
    task automatic send_byte(input logic is_cmd, input logic [7:0] value);
        @(posedge clk_sys);
        osd_cmd_wr  <= is_cmd;
        osd_data_wr <= ~is_cmd;
        osd_byte    <= value;
        @(posedge clk_sys);
        osd_cmd_wr  <= 1'b0;
        osd_data_wr <= 1'b0;
        if (is_cmd) begin
            if (value == CMD_OSD_ON) osd_on_model = 1'b1;
            if (value == CMD_OSD_OFF) osd_on_model = 1'b0;
            ld_state = (value == CMD_SET_ADDR) ? OSD_ADDR : OSD_IDLE;
        end else if (ld_state == OSD_ADDR) begin
            ld_addr  = value[6:0];
            ld_state = OSD_DATA;
        end else if (ld_state == OSD_DATA) begin
            bm_model[ld_addr] = value;
            ld_addr = ld_addr + 1'b1;
        end
    endtask

    task automatic run_frame(input logic mode, input int rate, input logic rnd,
                             input logic [11:0] solid);
        game_px_t    px;
        exp_px_t     e;
        logic        vis;
        logic [11:0] rgb;
        int          guard;
        for (int line = 0; line < FRAME_LN; line++) begin
            for (int col = 0; col < LINE_PX; col++) begin
                vis = (col < 96) && (line < 32);
                if (vis && rnd) rnd_state = xorshift32(rnd_state);
                rgb = !vis ? 12'h000 : (rnd ? rnd_state[11:0] : solid);
                px = '{r: rgb[11:8], g: rgb[7:4], b: rgb[3:0],
                       hs: (col >= 98 && col < 102), vs: (line == 32),
                       lhbl: (col < 96), lvbl: (line < 32)};
                @(posedge clk_sys);
                game_px <= px;
                pxl_cen <= 1'b1;
                ypbpr   <= mode;
                e.due  = neg_cnt + 3;       // Overlay register, then output register
                e.col  = col[8:0];
                e.line = line[8:0];
                e.vis  = vis;
                e.px   = ref_pixel(rgb, col, line, px.hs, px.vs, mode);
                exp_q.push_back(e);
                if (rate == 2) begin
                    @(posedge clk_sys);
                    pxl_cen <= 1'b0;
                end
            end
        end
        @(posedge clk_sys);
        pxl_cen <= 1'b0;
        guard = 0;
        while (exp_q.size() > 0 && guard < 20) begin
            @(posedge clk_sys);
            guard++;
        end
        if (exp_q.size() > 0) begin
            other_err_cnt++;
            $display("Timeout: outputs of %s never reached the checker", test_name);
            exp_q.delete();
        end
    endtask

    always @(negedge clk_sys) begin
        exp_px_t e;
        out_px_t act;
        neg_cnt = neg_cnt + 1;
        act = '{r: vga_r, g: vga_g, b: vga_b, hs: vga_hs, vs: vga_vs};
        while (exp_q.size() > 0 && exp_q[0].due <= neg_cnt) begin
            e = exp_q.pop_front();
            assert (act == e.px) else begin
                mismatch_cnt++;
                $display("mismatch %s pixel (%0d,%0d): expected %h, actual %h",
                         test_name, e.col, e.line, e.px, act);
            end
            if (e.vis) cap[e.line][e.col] = act;
        end
    end

    initial begin
        int          fd, n, cnt, frame_no, mode, rate, xc, xl;
        logic [7:0]  tag, value, er, eg, eb;
        logic [23:0] col_tok;
        logic [2047:0] skip;        // Rest of a comment line
        logic        done;
        out_px_t     act;
        rst_n = 1'b0;
        pxl_cen = 1'b0;
        ypbpr = 1'b0;
        game_px = '0;
        osd_cmd_wr = 1'b0;
        osd_data_wr = 1'b0;
        osd_byte = 8'h00;
        osd_on_model = 1'b0;
        ld_state = OSD_IDLE;
        ld_addr = '0;
        frame_no = 0;
        done = 1'b0;
        repeat (10) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        assert ({vga_r, vga_g, vga_b, vga_hs, vga_vs} == 20'd0) else begin
            mismatch_cnt++;
            $display("mismatch reset: expected %h, actual %h", 20'd0,
                     {vga_r, vga_g, vga_b, vga_hs, vga_vs});
        end
        fd = $fopen("video_stimulus.txt", "r");
        if (fd == 0) begin
            other_err_cnt++;
            $display("Could not open the stimulus file video_stimulus.txt");
            done = 1'b1;
        end
        while (!done) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                done = 1'b1;
            end else begin
                case (tag)
                    "#": n = $fgets(skip, fd);
                    "C": begin
                        n = $fscanf(fd, "%h", value);
                        send_byte(1'b1, value);
                    end
                    "D": begin
                        n = $fscanf(fd, "%h %d", value, cnt);
                        for (int k = 0; k < cnt; k++) begin
                            send_byte(1'b0, value + 8'(37 * k));
                        end
                    end
                    "F": begin
                        n = $fscanf(fd, "%d %d %s", mode, rate, col_tok);
                        frame_no++;
                        test_name = $sformatf("frame %0d (%s, rate 1/%0d)", frame_no,
                                              mode != 0 ? "ypbpr" : "rgb", rate);
                        run_frame(mode[0], rate, col_tok == "RND",
                                  {hex_nibble(col_tok[23:16]), hex_nibble(col_tok[15:8]),
                                   hex_nibble(col_tok[7:0])});
                    end
                    "X": begin
                        n = $fscanf(fd, "%d %d %h %h %h", xc, xl, er, eg, eb);
                        act = cap[xl][xc];
                        assert ({act.r, act.g, act.b} == {er[5:0], eg[5:0], eb[5:0]}) else begin
                            mismatch_cnt++;
                            $display("mismatch spot (%0d,%0d) of %s: expected %h, actual %h",
                                     xc, xl, test_name, {er[5:0], eg[5:0], eb[5:0]},
                                     {act.r, act.g, act.b});
                        end
                    end
                    default: begin
                        other_err_cnt++;
                        $display("Unknown record type in the stimulus file");
                        done = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        $display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: video_stimulus.txt
# C cmd | D data count (byte k of a run is data + 37*k) | F mode(0 rgb 1 ypbpr) rate(1 or 2) rgb|RND
# X col line r g b gives the expected 6-bit hex outputs of the last frame
F 0 1 RND
F 0 2 RND
C 20
D 00 1
D 00 128
C 41
F 0 2 A53
X 15 8 2A 15 0C
X 16 8 15 08 04
X 24 8 3F 3F 3F
X 25 8 15 08 04
X 26 8 3F 3F 3F
X 16 7 2A 15 0C
X 79 9 15 08 04
X 80 9 2A 15 0C
X 16 23 15 08 04
X 16 24 2A 15 0C
F 1 1 RND
C 20
D 08 1
D 81 1
D FF 1
C 41
D 55 3
F 0 1 A53
X 16 9 3F 3F 3F
X 17 9 15 08 04
X 23 9 3F 3F 3F
X 25 9 3F 3F 3F
X 26 8 3F 3F 3F
C 40
F 1 2 A53
X 16 9 2B 1A 17
F 0 1 RND

// File: vlog.f
video_pkg.sv
osd_pkg.sv
osd_loader.sv
video_pos_counter.sv
osd_overlay.sv
rgb2ypbpr.sv
video_out_mux.sv
video_base.sv
video_base_assert.sv
tb_video_base.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_video_base \
    -f vlog.f -o tb_video_base > build.log 2>&1 &&
{ ./obj_dir/tb_video_base > sim.log 2>&1 || true; } &&
grep -q "TEST PASSED" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
